//--- design/imuldiv_ctrl_pkg.sv
// divider controller types
// state encoding, step counter and step count

package imuldiv_ctrl_pkg;

  // idle -> calc for all steps -> done until the response is taken
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } div_state_t;

  // wide enough to hold the step count itself
  typedef logic [5:0] step_count_t;

  // one restoring step per quotient bit
  localparam int DIV_STEPS = 32;

endpackage

//--- design/imuldiv_pkg.sv
// divider data widths, word types and function codes
// shared by the datapath, the top level and the testbench

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // one operand, quotient or remainder
  localparam int WORD_W   = 32;
  // response word, remainder above quotient
  localparam int RESULT_W = 2 * WORD_W;
  // working register: remainder, dividend/quotient, plus a guard bit
  localparam int ACC_W    = RESULT_W + 1;

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [RESULT_W-1:0] result_t;
  typedef logic [ACC_W-1:0]    acc_t;

  // ----------------------------------------
  // function codes
  // ----------------------------------------

  // one bit on the request, selects how operands are read
  localparam logic FN_DIV_SIGNED   = 1'b0;
  localparam logic FN_DIV_UNSIGNED = 1'b1;

endpackage

//--- design/int_div_ctrl.sv
// divider controller
// state machine and step counter, drives the handshake and datapath enables

`timescale 1ns/10ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  import imuldiv_ctrl_pkg::*;

  div_state_t  state;
  step_count_t count;
  logic        req_go;
  logic        resp_go;
  logic        last_step;

  // handshakes complete on the edge where both sides are high
  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last_step = (count == step_count_t'(DIV_STEPS - 1));

  // ----------------------------------------
  // state and step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last step moves straight to done
          if (last_step) begin
            state <= DONE;
          end
          count <= count + step_count_t'(1);
        end
        DONE: begin
          // hold the result until it is taken
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // control outputs
  // ----------------------------------------

  always_comb begin
    req_rdy   = (state == IDLE);
    resp_val  = (state == DONE);
    // load on acceptance, step every calc cycle
    a_en      = ((state == IDLE) & req_val) | (state == CALC);
    b_en      = (state == IDLE) & req_val;
    // 0 picks the initial operand, 1 the step result
    a_mux_sel = (state == CALC);
  end

endmodule

//--- design/int_div_dpath.sv
// divider datapath
// operand magnitudes, working and divisor registers, restoring step, sign fix-up

`timescale 1ns/10ps

module int_div_dpath (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_fn,
  input  imuldiv_pkg::word_t   req_a,
  input  imuldiv_pkg::word_t   req_b,
  input  logic                 a_en,
  input  logic                 b_en,
  input  logic                 a_mux_sel,
  output imuldiv_pkg::result_t resp_result
);

  import imuldiv_pkg::*;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  logic  is_signed;
  logic  a_neg;
  logic  b_neg;
  word_t mag_a;
  word_t mag_b;

  // sign bits only count for a signed request
  assign is_signed = (req_fn == FN_DIV_SIGNED);
  assign a_neg     = is_signed & req_a[WORD_W-1];
  assign b_neg     = is_signed & req_b[WORD_W-1];

  // two's complement negate when negative
  assign mag_a = a_neg ? (~req_a + word_t'(1)) : req_a;
  assign mag_b = b_neg ? (~req_b + word_t'(1)) : req_b;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // upper half partial remainder, lower half dividend shifting into quotient
  acc_t acc_reg;
  // divisor magnitude lined up with the remainder half
  acc_t div_reg;
  logic neg_quot;
  logic neg_rem;

  acc_t acc_init;
  acc_t acc_shift;
  acc_t acc_diff;
  acc_t acc_step;

  // dividend zero-extended into the low half
  assign acc_init = {{(ACC_W-WORD_W){1'b0}}, mag_a};

  // one restoring step
  assign acc_shift = acc_reg << 1;
  assign acc_diff  = acc_shift - div_reg;
  // guard bit set means the subtract went negative, so restore
  assign acc_step  = acc_diff[ACC_W-1] ? {acc_shift[ACC_W-1:1], 1'b0}
                                       : {acc_diff[ACC_W-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (a_en) begin
      acc_reg <= a_mux_sel ? acc_step : acc_init;
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      div_reg <= {1'b0, mag_b, {WORD_W{1'b0}}};
    end
  end

  // sign flags captured with the divisor
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_quot <= 1'b0;
      neg_rem  <= 1'b0;
    end else if (b_en) begin
      // quotient negative when exactly one operand is
      neg_quot <= a_neg ^ b_neg;
      // remainder follows the dividend
      neg_rem  <= a_neg;
    end
  end

  // ----------------------------------------
  // result
  // ----------------------------------------

  word_t quot_mag;
  word_t rem_mag;
  word_t quot_out;
  word_t rem_out;

  assign quot_mag = acc_reg[WORD_W-1:0];
  assign rem_mag  = acc_reg[RESULT_W-1:WORD_W];

  assign quot_out = neg_quot ? (~quot_mag + word_t'(1)) : quot_mag;
  assign rem_out  = neg_rem  ? (~rem_mag + word_t'(1))  : rem_mag;

  // remainder in the upper half, quotient in the lower
  assign resp_result = {rem_out, quot_out};

endmodule

//--- design/int_div_iterative.sv
// iterative 32-bit divide unit top level
// joins the controller and datapath to the request/response handshake

`timescale 1ns/10ps

module int_div_iterative (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  logic                 req_fn,
  input  imuldiv_pkg::word_t   req_a,
  input  imuldiv_pkg::word_t   req_b,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output imuldiv_pkg::result_t resp_result
);

  // controller to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;

  // ----------------------------------------
  // controller
  // ----------------------------------------

  int_div_ctrl i_int_div_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  int_div_dpath i_int_div_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .resp_result (resp_result)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the divider testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=int_div_sim
LOG=sim.log

verilator --binary --timing -f tb.f --top-module int_div_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if grep -qx "Testbench passed" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail, see $LOG"
  exit 1
fi

//--- sim/int_div_tb.sv
// testbench for the iterative divide unit
// random requests and back-pressure, reference model, checks and watchdog

`timescale 1ns/10ps

module int_div_tb;

  import imuldiv_pkg::*;
  import imuldiv_ctrl_pkg::*;

  // ----------------------------------------
  // run length and limits
  // ----------------------------------------

  localparam int CLK_PERIOD = 100;
  localparam int MAX_STALL  = 10;
  localparam int N_UNSIGNED = 300;
  localparam int N_SIGNED   = 200;
  localparam int N_CORNER   = 10;
  localparam int N_ZERO     = 6;
  localparam int N_OPS      = N_UNSIGNED + N_SIGNED + N_CORNER + N_ZERO;
  // per op the steps and worst stall plus accept, take and idle cycles
  localparam longint WATCHDOG_NS = longint'(N_OPS) * (DIV_STEPS + MAX_STALL + 4) * CLK_PERIOD
                                   + 200 * CLK_PERIOD;

  logic    clk;
  logic    reset;
  logic    req_val;
  logic    req_rdy;
  logic    req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    resp_val;
  logic    resp_rdy;
  result_t resp_result;

  integer seed;
  int     pass_count;
  int     fail_count;

  int_div_iterative i_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // magnitudes divided unsigned, then sign rules; divide by zero gives all ones
  function automatic result_t div_model(input logic fn, input word_t a, input word_t b);
    logic  a_neg;
    logic  b_neg;
    word_t mag_a;
    word_t mag_b;
    word_t quot;
    word_t rem;
    a_neg = (fn == FN_DIV_SIGNED) && a[WORD_W-1];
    b_neg = (fn == FN_DIV_SIGNED) && b[WORD_W-1];
    mag_a = a_neg ? -a : a;
    mag_b = b_neg ? -b : b;
    if (mag_b == '0) begin
      quot = '1;
      rem  = mag_a;
    end else begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end
    // quotient negative for exactly one negative operand
    if (a_neg ^ b_neg) begin
      quot = -quot;
    end
    // remainder takes the dividend sign
    if (a_neg) begin
      rem = -rem;
    end
    return {rem, quot};
  endfunction

  task automatic check(input string name, input result_t expected, input result_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // ----------------------------------------
  // one division through the handshake
  // ----------------------------------------

  // called on a falling edge, returns on a falling edge with the unit idle
  task automatic run_div(input string name, input logic fn, input word_t a, input word_t b);
    result_t expected;
    result_t held;
    int      cycles;
    int      stall;
    logic    busy_rdy;
    logic    stall_bad;
    expected = div_model(fn, a, b);
    req_val  = 1'b1;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    cycles   = 0;
    while (!req_rdy && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      $display("%s: the DUT never raised req_rdy for the request", name);
      fail_count++;
    end
    // accepting edge falls inside this wait
    @(negedge clk);
    req_val = 1'b0;
    // operands must be captured, so scramble them
    req_fn  = ~fn;
    req_a   = $random(seed);
    req_b   = $random(seed);
    cycles   = 1;
    busy_rdy = 1'b0;
    while (!resp_val && cycles < DIV_STEPS + 8) begin
      busy_rdy = busy_rdy | req_rdy;
      @(negedge clk);
      cycles++;
    end
    if (!resp_val) begin
      $display("%s: no response from the DUT after %0d cycles", name, cycles);
      fail_count++;
    end else begin
      // load on the accepting edge, then one edge per step
      check({name, " latency"}, result_t'(DIV_STEPS + 1), result_t'(cycles));
      check({name, " req_rdy while busy"}, result_t'(0), result_t'(busy_rdy));
      check({name, " result"}, expected, resp_result);
      held      = resp_result;
      stall     = $unsigned($random(seed)) % (MAX_STALL + 1);
      stall_bad = 1'b0;
      repeat (stall) begin
        @(negedge clk);
        if (resp_result !== held || resp_val !== 1'b1 || req_rdy !== 1'b0) begin
          stall_bad = 1'b1;
        end
      end
      check({name, " held under back-pressure"}, result_t'(0), result_t'(stall_bad));
      resp_rdy = 1'b1;
      @(negedge clk);
      resp_rdy = 1'b0;
      // taken on the last edge, idle now
      check({name, " req_rdy after take"}, result_t'(1), result_t'(req_rdy));
      check({name, " resp_val after take"}, result_t'(0), result_t'(resp_val));
    end
  endtask

  task automatic report_test(input string name, input int ops, input int fails_before);
    if (fail_count == fails_before) begin
      $display("test %s: %0d ops, ok", name, ops);
    end else begin
      $display("test %s: %0d ops, %0d failed checks", name, ops, fail_count - fails_before);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int    fails;
    int    shift;
    word_t a;
    word_t b;
    clk        = 1'b0;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = FN_DIV_UNSIGNED;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    seed       = 80;
    pass_count = 0;
    fail_count = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    fails = fail_count;
    check("reset req_rdy", result_t'(1), result_t'(req_rdy));
    check("reset resp_val", result_t'(0), result_t'(resp_val));
    report_test("reset", 0, fails);

    // divisor shifted down so quotients vary in size
    fails = fail_count;
    for (int i = 0; i < N_UNSIGNED; i++) begin
      a     = $random(seed);
      b     = $random(seed);
      shift = $unsigned($random(seed)) % WORD_W;
      b     = b >> shift;
      run_div("unsigned random", FN_DIV_UNSIGNED, a, b);
    end
    report_test("unsigned random", N_UNSIGNED, fails);

    fails = fail_count;
    for (int i = 0; i < N_SIGNED; i++) begin
      a     = $random(seed);
      b     = $random(seed);
      shift = $unsigned($random(seed)) % WORD_W;
      b     = b >> shift;
      if ($random(seed) & 1) begin
        b = -b;
      end
      run_div("signed random", FN_DIV_SIGNED, a, b);
    end
    report_test("signed random", N_SIGNED, fails);

    fails = fail_count;
    run_div("signed zero dividend", FN_DIV_SIGNED, 32'h0000_0000, 32'h0000_0005);
    run_div("signed zero by negative", FN_DIV_SIGNED, 32'h0000_0000, 32'hffff_fff9);
    run_div("signed by one", FN_DIV_SIGNED, 32'hdead_beef, 32'h0000_0001);
    run_div("signed by minus one", FN_DIV_SIGNED, 32'h1234_5678, 32'hffff_ffff);
    run_div("signed overflow", FN_DIV_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    run_div("signed min by one", FN_DIV_SIGNED, 32'h8000_0000, 32'h0000_0001);
    run_div("signed neg by pos", FN_DIV_SIGNED, 32'hffff_fff9, 32'h0000_0002);
    run_div("signed pos by neg", FN_DIV_SIGNED, 32'h0000_0007, 32'hffff_fffe);
    run_div("signed max by minus one", FN_DIV_SIGNED, 32'h7fff_ffff, 32'hffff_ffff);
    run_div("signed neg by neg", FN_DIV_SIGNED, 32'hffff_ff9c, 32'hffff_fff9);
    report_test("signed corners", N_CORNER, fails);

    fails = fail_count;
    run_div("unsigned by zero", FN_DIV_UNSIGNED, 32'h0000_0005, 32'h0000_0000);
    run_div("unsigned max by zero", FN_DIV_UNSIGNED, 32'hffff_ffff, 32'h0000_0000);
    run_div("unsigned zero by zero", FN_DIV_UNSIGNED, 32'h0000_0000, 32'h0000_0000);
    run_div("signed pos by zero", FN_DIV_SIGNED, 32'h0000_0005, 32'h0000_0000);
    run_div("signed neg by zero", FN_DIV_SIGNED, 32'hffff_fffb, 32'h0000_0000);
    run_div("signed min by zero", FN_DIV_SIGNED, 32'h8000_0000, 32'h0000_0000);
    report_test("divide by zero", N_ZERO, fails);

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- tb.f
design/imuldiv_pkg.sv
design/imuldiv_ctrl_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
sim/int_div_tb.sv
